//--- logic/axi_rd_pkg.sv
package axi_rd_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int LEN_W    = 4;   // burst has len+1 beats
    localparam int RESP_W   = 2;
    localparam int REGION_W = 1;   // top address bits that pick the slave

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // one address word, read flat when forwarded and split when routed
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0]        region;
            logic [ADDR_W-REGION_W-1:0] offset;
        } fields;
    } addr_word_u;

endpackage

//--- logic/route_pkg.sv
package route_pkg;

    import axi_rd_pkg::*;

    // every region code maps to a slave, so no decode error path exists
    localparam int NUM_OUTPUTS = 2 ** REGION_W;
    localparam int OUT_IDX_W   = REGION_W;   // slave index in a route record

endpackage

//--- logic/ar_command_router.sv
`timescale 1ns/1ps

module ar_command_router
    import axi_rd_pkg::*;
    import route_pkg::*;
#(
    parameter int INPUTS = 2,
    localparam int IN_IDX_W = (INPUTS > 1) ? $clog2(INPUTS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [INPUTS-1:0]             in_ar_valid,
    output logic [INPUTS-1:0]             in_ar_ready,
    input  logic [INPUTS*ADDR_W-1:0]      in_ar_addr,
    input  logic [INPUTS*LEN_W-1:0]       in_ar_len,
    output logic [NUM_OUTPUTS-1:0]        out_ar_valid,
    input  logic [NUM_OUTPUTS-1:0]        out_ar_ready,
    output logic [NUM_OUTPUTS*ADDR_W-1:0] out_ar_addr,
    output logic [NUM_OUTPUTS*LEN_W-1:0]  out_ar_len,
    input  logic                          route_full,
    output logic                          route_push,
    output logic [IN_IDX_W-1:0]           route_in,
    output logic [OUT_IDX_W-1:0]          route_out
);

    logic                 grant_found;
    logic [IN_IDX_W-1:0]  grant_idx;
    logic [IN_IDX_W-1:0]  rr_ptr;      // first master to look at
    addr_word_u           sel_word;
    logic                 stage_free;
    logic                 accept;

    logic                 stg_valid;
    logic [OUT_IDX_W-1:0] stg_out;
    addr_word_u           stg_addr;
    logic [LEN_W-1:0]     stg_len;

    // round-robin search starting at rr_ptr
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < INPUTS; i++) begin
            idx = (int'(rr_ptr) + i) % INPUTS;
            if (!grant_found && in_ar_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = IN_IDX_W'(idx);
            end
        end
    end

    assign sel_word.raw = in_ar_addr[grant_idx*ADDR_W +: ADDR_W];

    // stage takes a new command when empty or draining this cycle
    assign stage_free = !stg_valid || out_ar_ready[stg_out];
    assign accept     = grant_found && stage_free && !route_full;

    always_comb begin
        in_ar_ready            = '0;
        in_ar_ready[grant_idx] = accept;   // winner only
    end

    assign route_push = accept;
    assign route_in   = grant_idx;
    assign route_out  = sel_word.fields.region;   // top bits pick the slave

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stg_valid <= 1'b0;
            stg_out   <= '0;
            rr_ptr    <= '0;
        end else begin
            if (accept) begin
                stg_valid <= 1'b1;
                stg_out   <= sel_word.fields.region;
                rr_ptr    <= (int'(grant_idx) == INPUTS - 1) ? '0 : grant_idx + 1'b1;
            end else if (stg_valid && out_ar_ready[stg_out]) begin
                stg_valid <= 1'b0;
            end
        end
    end

    // command payload, qualified by stg_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            stg_addr <= sel_word;
            stg_len  <= in_ar_len[grant_idx*LEN_W +: LEN_W];
        end
    end

    always_comb begin
        out_ar_valid          = '0;
        out_ar_valid[stg_out] = stg_valid;   // only the decoded slave sees it
    end

    assign out_ar_addr = {NUM_OUTPUTS{stg_addr.raw}};
    assign out_ar_len  = {NUM_OUTPUTS{stg_len}};

    // slave side must see a held command until it takes it
    property p_stage_hold;
        @(posedge clk) disable iff (!arst_n)
        (stg_valid && !out_ar_ready[stg_out])
            |=> ($stable(out_ar_valid) && $stable(out_ar_addr) && $stable(out_ar_len));
    endproperty

    a_stage_hold: assert property (p_stage_hold)
        else $error("ar stage changed while stalled");

endmodule

//--- logic/route_fifo.sv
`timescale 1ns/1ps

module route_fifo
    import route_pkg::*;
#(
    parameter int INPUTS = 2,
    parameter int MOT    = 8,
    localparam int IN_IDX_W = (INPUTS > 1) ? $clog2(INPUTS) : 1
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 route_push,
    input  logic [IN_IDX_W-1:0]  route_in,
    input  logic [OUT_IDX_W-1:0] route_out,
    output logic                 route_full,
    input  logic                 route_pop,
    output logic                 route_valid,
    output logic [IN_IDX_W-1:0]  head_in,
    output logic [OUT_IDX_W-1:0] head_out
);

    localparam int PTR_W = (MOT > 1) ? $clog2(MOT) : 1;
    localparam int CNT_W = $clog2(MOT + 1);

    logic [IN_IDX_W-1:0]  in_mem  [MOT];
    logic [OUT_IDX_W-1:0] out_mem [MOT];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;    // entries in flight

    // wraps at MOT, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == MOT - 1) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (route_push) wr_ptr <= next_ptr(wr_ptr);
            if (route_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({route_push, route_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (route_push) begin
            in_mem[wr_ptr]  <= route_in;
            out_mem[wr_ptr] <= route_out;
        end
    end

    assign route_full  = (int'(count) == MOT);
    assign route_valid = (count != '0);
    assign head_in     = in_mem[rd_ptr];
    assign head_out    = out_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        route_push |-> !route_full) else $error("route push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        route_pop |-> route_valid) else $error("route pop while empty");

endmodule

//--- logic/r_data_steer.sv
`timescale 1ns/1ps

module r_data_steer
    import axi_rd_pkg::*;
    import route_pkg::*;
#(
    parameter int INPUTS = 2,
    localparam int IN_IDX_W = (INPUTS > 1) ? $clog2(INPUTS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          route_valid,
    input  logic [IN_IDX_W-1:0]           head_in,
    input  logic [OUT_IDX_W-1:0]          head_out,
    output logic                          route_pop,
    input  logic [NUM_OUTPUTS-1:0]        out_r_valid,
    output logic [NUM_OUTPUTS-1:0]        out_r_ready,
    input  logic [NUM_OUTPUTS-1:0]        out_r_last,
    input  logic [NUM_OUTPUTS*DATA_W-1:0] out_r_data,
    input  logic [NUM_OUTPUTS*RESP_W-1:0] out_r_resp,
    output logic [INPUTS-1:0]             in_r_valid,
    input  logic [INPUTS-1:0]             in_r_ready,
    output logic [INPUTS-1:0]             in_r_last,
    output logic [INPUTS*DATA_W-1:0]      in_r_data,
    output logic [INPUTS*RESP_W-1:0]      in_r_resp
);

    logic              src_valid;   // head slave has a beat
    logic              sink_ready;  // head master can take it
    logic              src_last;
    logic [DATA_W-1:0] src_data;
    logic [RESP_W-1:0] src_resp;
    logic              beat_xfer;

    assign src_valid  = route_valid && out_r_valid[head_out];
    assign sink_ready = route_valid && in_r_ready[head_in];
    assign src_last   = out_r_last[head_out];
    assign src_data   = out_r_data[head_out*DATA_W +: DATA_W];
    assign src_resp   = out_r_resp[head_out*RESP_W +: RESP_W];

    assign beat_xfer = src_valid && sink_ready;
    assign route_pop = beat_xfer && src_last;   // burst done, retire route

    // only the head pair sees a handshake, the rest stay idle
    always_comb begin
        in_r_valid           = '0;
        in_r_valid[head_in]  = src_valid;
        out_r_ready          = '0;
        out_r_ready[head_out] = sink_ready;
    end

    // payload fans out to all masters, valid picks the owner
    assign in_r_last = {INPUTS{src_last}};
    assign in_r_data = {INPUTS{src_data}};
    assign in_r_resp = {INPUTS{src_resp}};   // response passes unchanged

    // the open read keeps its pairing until its last beat
    a_head_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (route_valid && !route_pop)
            |=> (route_valid && $stable(head_in) && $stable(head_out)))
        else $error("route head changed before its last beat");

endmodule

//--- logic/axi_rd_router.sv
`timescale 1ns/1ps

module axi_rd_router
    import axi_rd_pkg::*;
    import route_pkg::*;
#(
    parameter int INPUTS = 2,
    parameter int MOT    = 8,
    localparam int IN_IDX_W = (INPUTS > 1) ? $clog2(INPUTS) : 1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    // masters
    input  logic [INPUTS-1:0]             in_ar_valid,
    output logic [INPUTS-1:0]             in_ar_ready,
    input  logic [INPUTS*ADDR_W-1:0]      in_ar_addr,
    input  logic [INPUTS*LEN_W-1:0]       in_ar_len,
    output logic [INPUTS-1:0]             in_r_valid,
    input  logic [INPUTS-1:0]             in_r_ready,
    output logic [INPUTS-1:0]             in_r_last,
    output logic [INPUTS*DATA_W-1:0]      in_r_data,
    output logic [INPUTS*RESP_W-1:0]      in_r_resp,
    // slaves
    output logic [NUM_OUTPUTS-1:0]        out_ar_valid,
    input  logic [NUM_OUTPUTS-1:0]        out_ar_ready,
    output logic [NUM_OUTPUTS*ADDR_W-1:0] out_ar_addr,
    output logic [NUM_OUTPUTS*LEN_W-1:0]  out_ar_len,
    input  logic [NUM_OUTPUTS-1:0]        out_r_valid,
    output logic [NUM_OUTPUTS-1:0]        out_r_ready,
    input  logic [NUM_OUTPUTS-1:0]        out_r_last,
    input  logic [NUM_OUTPUTS*DATA_W-1:0] out_r_data,
    input  logic [NUM_OUTPUTS*RESP_W-1:0] out_r_resp
);

    logic                 route_push;
    logic [IN_IDX_W-1:0]  route_in;
    logic [OUT_IDX_W-1:0] route_out;
    logic                 route_full;
    logic                 route_pop;
    logic                 route_valid;
    logic [IN_IDX_W-1:0]  head_in;
    logic [OUT_IDX_W-1:0] head_out;

    ar_command_router #(.INPUTS(INPUTS)) u_cmd (
        .clk, .arst_n,
        .in_ar_valid, .in_ar_ready, .in_ar_addr, .in_ar_len,
        .out_ar_valid, .out_ar_ready, .out_ar_addr, .out_ar_len,
        .route_full, .route_push, .route_in, .route_out
    );

    // issue order of all reads, head owns the data channel
    route_fifo #(.INPUTS(INPUTS), .MOT(MOT)) u_routes (
        .clk, .arst_n,
        .route_push, .route_in, .route_out, .route_full,
        .route_pop, .route_valid, .head_in, .head_out
    );

    r_data_steer #(.INPUTS(INPUTS)) u_steer (
        .clk, .arst_n,
        .route_valid, .head_in, .head_out, .route_pop,
        .out_r_valid, .out_r_ready, .out_r_last, .out_r_data, .out_r_resp,
        .in_r_valid, .in_r_ready, .in_r_last, .in_r_data, .in_r_resp
    );

endmodule

//--- test/tb_axi_rd_router.sv
`timescale 1ns/1ps

module tb_axi_rd_router
    import axi_rd_pkg::*;
    import route_pkg::*;
;

    localparam int INPUTS      = 2;
    localparam int MOT         = 8;
    localparam int READS       = 40;   // per master
    localparam int TOTAL_READS = INPUTS * READS;
    // 80 reads of up to 16 beats, throttled up to 4x, plus margin
    localparam int MAX_CYCLES  = 20000;

    logic                          clk;
    logic                          arst_n;
    logic [INPUTS-1:0]             in_ar_valid;
    logic [INPUTS-1:0]             in_ar_ready;
    logic [INPUTS*ADDR_W-1:0]      in_ar_addr;
    logic [INPUTS*LEN_W-1:0]       in_ar_len;
    logic [INPUTS-1:0]             in_r_valid;
    logic [INPUTS-1:0]             in_r_ready;
    logic [INPUTS-1:0]             in_r_last;
    logic [INPUTS*DATA_W-1:0]      in_r_data;
    logic [INPUTS*RESP_W-1:0]      in_r_resp;
    logic [NUM_OUTPUTS-1:0]        out_ar_valid;
    logic [NUM_OUTPUTS-1:0]        out_ar_ready;
    logic [NUM_OUTPUTS*ADDR_W-1:0] out_ar_addr;
    logic [NUM_OUTPUTS*LEN_W-1:0]  out_ar_len;
    logic [NUM_OUTPUTS-1:0]        out_r_valid;
    logic [NUM_OUTPUTS-1:0]        out_r_ready;
    logic [NUM_OUTPUTS-1:0]        out_r_last;
    logic [NUM_OUTPUTS*DATA_W-1:0] out_r_data;
    logic [NUM_OUTPUTS*RESP_W-1:0] out_r_resp;

    // master models
    logic              ar_busy    [INPUTS];   // command held on the bus
    logic [ADDR_W-1:0] ar_addr_r  [INPUTS];
    logic [LEN_W-1:0]  ar_len_r   [INPUTS];
    int                ar_issued  [INPUTS];
    int                m_beat     [INPUTS];
    logic [ADDR_W-1:0] exp_addr_q [INPUTS][$];   // reads per master, acceptance order
    logic [LEN_W-1:0]  exp_len_q  [INPUTS][$];

    // accepted but not yet taken by a slave
    logic [ADDR_W-1:0] cmd_addr_q [$];
    logic [LEN_W-1:0]  cmd_len_q  [$];

    // slave models
    logic              sl_rvalid  [NUM_OUTPUTS];
    int                sl_beat    [NUM_OUTPUTS];
    logic [ADDR_W-1:0] sl_addr_q  [NUM_OUTPUTS][$];
    logic [LEN_W-1:0]  sl_len_q   [NUM_OUTPUTS][$];

    int                completed;
    int                cycles;

    axi_rd_router #(.INPUTS(INPUTS), .MOT(MOT)) dut (
        .clk, .arst_n,
        .in_ar_valid, .in_ar_ready, .in_ar_addr, .in_ar_len,
        .in_r_valid, .in_r_ready, .in_r_last, .in_r_data, .in_r_resp,
        .out_ar_valid, .out_ar_ready, .out_ar_addr, .out_ar_len,
        .out_r_valid, .out_r_ready, .out_r_last, .out_r_data, .out_r_resp
    );

    always #4 clk = ~clk;

    // slaves flag address bit 2 as an error
    function automatic logic [RESP_W-1:0] expected_resp(input logic [ADDR_W-1:0] addr);
        return addr[2] ? RESP_SLVERR : RESP_OKAY;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("FAIL %s expected %h actual %h", test_name, expected, actual));
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (in_ar_ready == '0)
            else report_mismatch({phase, " in_ar_ready"}, 32'h0, 32'(in_ar_ready));
        assert (out_ar_valid == '0)
            else report_mismatch({phase, " out_ar_valid"}, 32'h0, 32'(out_ar_valid));
        assert (in_r_valid == '0)
            else report_mismatch({phase, " in_r_valid"}, 32'h0, 32'(in_r_valid));
        assert (out_r_ready == '0)
            else report_mismatch({phase, " out_r_ready"}, 32'h0, 32'(out_r_ready));
    endtask

    // called on the falling edge
    task automatic drive_inputs();
        for (int m = 0; m < INPUTS; m++) begin
            if (!ar_busy[m] && ar_issued[m] < READS && $urandom % 2 == 0) begin
                ar_busy[m]   = 1'b1;
                ar_addr_r[m] = $urandom;
                ar_len_r[m]  = LEN_W'($urandom % 16);
                ar_issued[m]++;
            end
            in_ar_valid[m]                 = ar_busy[m];
            in_ar_addr[m*ADDR_W +: ADDR_W] = ar_addr_r[m];
            in_ar_len[m*LEN_W +: LEN_W]    = ar_len_r[m];
            in_r_ready[m]                  = ($urandom % 4) != 0;   // random stalls
        end
        for (int s = 0; s < NUM_OUTPUTS; s++) begin
            out_ar_ready[s] = ($urandom % 3) != 0;
            if (!sl_rvalid[s] && sl_addr_q[s].size() > 0 && $urandom % 4 != 0)
                sl_rvalid[s] = 1'b1;   // held until the beat is taken
            out_r_valid[s] = sl_rvalid[s];
            if (sl_addr_q[s].size() > 0) begin
                out_r_data[s*DATA_W +: DATA_W] = sl_addr_q[s][0] + DATA_W'(sl_beat[s]);
                out_r_last[s]                  = (sl_beat[s] == int'(sl_len_q[s][0]));
                out_r_resp[s*RESP_W +: RESP_W] = expected_resp(sl_addr_q[s][0]);
            end else begin
                out_r_data[s*DATA_W +: DATA_W] = '0;
                out_r_last[s]                  = 1'b0;
                out_r_resp[s*RESP_W +: RESP_W] = RESP_OKAY;
            end
        end
    endtask

    // called on the rising edge, before any register updates
    task automatic observe_transfers();
        logic [ADDR_W-1:0] exp_a;
        logic [LEN_W-1:0]  exp_l;
        logic              last_exp;
        for (int m = 0; m < INPUTS; m++) begin
            if (in_ar_valid[m] && in_ar_ready[m]) begin
                exp_addr_q[m].push_back(ar_addr_r[m]);
                exp_len_q[m].push_back(ar_len_r[m]);
                cmd_addr_q.push_back(ar_addr_r[m]);
                cmd_len_q.push_back(ar_len_r[m]);
                ar_busy[m] = 1'b0;
            end
        end
        for (int s = 0; s < NUM_OUTPUTS; s++) begin
            if (out_ar_valid[s] && out_ar_ready[s]) begin
                assert (cmd_addr_q.size() > 0)
                    else stop_with_failure("a slave received a command no master issued");
                exp_a = cmd_addr_q.pop_front();
                exp_l = cmd_len_q.pop_front();
                assert (OUT_IDX_W'(s) == exp_a[ADDR_W-1 -: REGION_W])
                    else report_mismatch("routing slave", 32'(exp_a[ADDR_W-1 -: REGION_W]), 32'(s));
                assert (out_ar_addr[s*ADDR_W +: ADDR_W] == exp_a)
                    else report_mismatch("routing addr", exp_a, out_ar_addr[s*ADDR_W +: ADDR_W]);
                assert (out_ar_len[s*LEN_W +: LEN_W] == exp_l)
                    else report_mismatch("routing len", 32'(exp_l), 32'(out_ar_len[s*LEN_W +: LEN_W]));
                sl_addr_q[s].push_back(exp_a);
                sl_len_q[s].push_back(exp_l);
            end
            if (out_r_valid[s] && out_r_ready[s]) begin
                sl_rvalid[s] = 1'b0;
                if (sl_beat[s] == int'(sl_len_q[s][0])) begin
                    void'(sl_addr_q[s].pop_front());
                    void'(sl_len_q[s].pop_front());
                    sl_beat[s] = 0;
                end else begin
                    sl_beat[s]++;
                end
            end
        end
        for (int m = 0; m < INPUTS; m++) begin
            if (in_r_valid[m] && in_r_ready[m]) begin
                assert (exp_addr_q[m].size() > 0)
                    else stop_with_failure($sformatf("master %0d got a beat with no read open", m));
                exp_a    = exp_addr_q[m][0];
                exp_l    = exp_len_q[m][0];
                last_exp = (m_beat[m] == int'(exp_l));
                assert (in_r_data[m*DATA_W +: DATA_W] == exp_a + DATA_W'(m_beat[m]))
                    else report_mismatch($sformatf("data master %0d", m),
                        exp_a + DATA_W'(m_beat[m]), in_r_data[m*DATA_W +: DATA_W]);
                assert (in_r_last[m] == last_exp)
                    else report_mismatch($sformatf("last master %0d", m),
                        32'(last_exp), 32'(in_r_last[m]));
                assert (in_r_resp[m*RESP_W +: RESP_W] == expected_resp(exp_a))
                    else report_mismatch($sformatf("resp master %0d", m),
                        32'(expected_resp(exp_a)), 32'(in_r_resp[m*RESP_W +: RESP_W]));
                if (last_exp) begin
                    void'(exp_addr_q[m].pop_front());
                    void'(exp_len_q[m].pop_front());
                    m_beat[m] = 0;
                    completed++;
                end else begin
                    m_beat[m]++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h157f));
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_ar_valid  = '0;
        in_ar_addr   = '0;
        in_ar_len    = '0;
        in_r_ready   = '1;   // masters ready and slaves offering stray beats
        out_ar_ready = '1;
        out_r_valid  = '1;
        out_r_last   = '0;
        out_r_data   = '0;
        out_r_resp   = '0;
        for (int m = 0; m < INPUTS; m++) begin
            ar_busy[m]   = 1'b0;
            ar_addr_r[m] = '0;
            ar_len_r[m]  = '0;
            ar_issued[m] = 0;
            m_beat[m]    = 0;
        end
        for (int s = 0; s < NUM_OUTPUTS; s++) begin
            sl_rvalid[s] = 1'b0;
            sl_beat[s]   = 0;
        end
        completed = 0;
        cycles    = 0;

        repeat (4) begin
            @(posedge clk);
            check_idle_outputs("reset");
        end
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        check_idle_outputs("after reset");   // no read open yet, stray beats must stay out

        while (completed < TOTAL_READS) begin
            @(negedge clk);
            drive_inputs();
            @(posedge clk);
            observe_transfers();
            cycles++;
            if (cycles >= MAX_CYCLES)
                stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d reads done",
                    cycles, completed, TOTAL_READS));
        end

        for (int m = 0; m < INPUTS; m++) begin
            assert (ar_issued[m] == READS && !ar_busy[m] && exp_addr_q[m].size() == 0)
                else stop_with_failure($sformatf("master %0d has reads left over", m));
        end
        assert (cmd_addr_q.size() == 0 && sl_addr_q[0].size() == 0 && sl_addr_q[1].size() == 0)
            else stop_with_failure("commands left in the slave models");

        // quiet tail, any extra beat would be a duplicate
        repeat (10) begin
            @(negedge clk);
            drive_inputs();
            out_r_valid = '1;   // stray slave beats with every read retired
            @(posedge clk);
            assert (in_r_valid == '0)
                else report_mismatch("extra beat", 32'h0, 32'(in_r_valid));
            assert (out_r_ready == '0)
                else report_mismatch("stray beat taken", 32'h0, 32'(out_r_ready));
            assert (out_ar_valid == '0)
                else report_mismatch("extra command", 32'h0, 32'(out_ar_valid));
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- axi_rd_router.f
logic/axi_rd_pkg.sv
logic/route_pkg.sv
logic/ar_command_router.sv
logic/route_fifo.sv
logic/r_data_steer.sv
logic/axi_rd_router.sv
test/tb_axi_rd_router.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_axi_rd_router
FILELIST  ?= axi_rd_router.f
RTL_TOP   ?= axi_rd_router
RTL_FILES := $(filter-out test/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf obj_dir
